/* hdl/chipset_pkg.sv */
package chipset_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    // Decoded target of a request
    typedef enum logic [1:0] {
        REGION_RAM     = 2'd0,
        REGION_DISPLAY = 2'd1,
        REGION_SWITCH  = 2'd2,
        REGION_NONE    = 2'd3
    } region_e;

    // Memory map
    localparam logic [3:0] RAM_REGION_NIBBLE = 4'h1;
    localparam word_t      DISPLAY_ADDR      = 32'hFF00_0000;
    localparam word_t      SWITCH_ADDR       = 32'hFF00_0004;

    // Request from the master
    typedef struct packed {
        bus_op_e    op;
        word_t      addr;
        word_t      write_data;
        logic [3:0] write_mask;
    } bus_req_t;

    // Issue to one target
    typedef struct packed {
        logic       valid;
        bus_op_e    op;
        region_e    region;
        word_t      addr;
        word_t      write_data;
        logic [3:0] write_mask;
    } target_req_t;

    // Marks a read issued in the previous cycle
    typedef struct packed {
        logic    valid;
        region_e region;
    } read_tag_t;

    typedef word_t bus_rsp_t;

endpackage

/* hdl/reset_stretch.sv */
`timescale 1ns/100ps

module reset_stretch #(
    parameter int RESET_CYCLES = 12
) (
    input  wire logic clk_cpu_i,
    input  wire logic reset_async_i,
    output logic      reset_o
);

    localparam logic [RESET_CYCLES-1:0] CHAIN_ONES = {RESET_CYCLES{1'b1}};

    logic [RESET_CYCLES-1:0] chain_r;

    always_ff @(posedge clk_cpu_i) begin
        if (reset_async_i) begin
            // Load ones while the input is held
            {reset_o, chain_r} <= {1'b1, CHAIN_ONES};
        end else begin
            // Drain the ones one per cycle
            {reset_o, chain_r} <= {chain_r, 1'b0};
        end
    end

endmodule

/* hdl/bus_decoder.sv */
`timescale 1ns/100ps

module bus_decoder
    import chipset_pkg::*;
#(
    parameter int REQ_DEPTH   = 4,
    parameter int RSP_CREDITS = 2
) (
    input  wire logic      clk_cpu_i,
    input  wire logic      reset_i,
    input  wire logic      req_valid_i,
    input  wire bus_req_t  req_i,
    output logic           req_credit_o,
    input  wire logic      rsp_credit_i,
    output target_req_t    ram_req_o,
    output target_req_t    io_req_o,
    output read_tag_t      read_tag_o
);

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);
    localparam int RCW   = $clog2(RSP_CREDITS + 1);

    bus_req_t             queue_r [REQ_DEPTH];
    logic     [PTR_W-1:0] wr_ptr_r;
    logic     [PTR_W-1:0] rd_ptr_r;
    logic     [CNT_W-1:0] count_r;
    logic     [CNT_W-1:0] owed_r;
    logic     [RCW-1:0]   rsp_cred_r;

    bus_req_t    head_w;
    region_e     head_region_w;
    logic        pop_w;
    logic        read_pop_w;
    logic        credit_pulse_w;
    target_req_t issue_w;

    function automatic region_e decode_region(input word_t addr);
        region_e region;
        if (addr[31:28] == RAM_REGION_NIBBLE) begin
            region = REGION_RAM;
        end else if (addr == DISPLAY_ADDR) begin
            region = REGION_DISPLAY;
        end else if (addr == SWITCH_ADDR) begin
            region = REGION_SWITCH;
        end else begin
            region = REGION_NONE;
        end
        return region;
    endfunction

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_w        = queue_r[rd_ptr_r];
    assign head_region_w = decode_region(head_w.addr);

    // Reads need a response slot, writes go straight through
    assign pop_w      = (count_r != '0) && ((head_w.op == BUS_WRITE) || (rsp_cred_r != '0));
    assign read_pop_w = pop_w && (head_w.op == BUS_READ);

    // Owed credits cover the initial grant and every popped slot
    assign credit_pulse_w = (owed_r != '0) || pop_w;

    always_ff @(posedge clk_cpu_i) begin
        if (req_valid_i) begin
            queue_r[wr_ptr_r] <= req_i;
        end
    end

    always_ff @(posedge clk_cpu_i) begin
        if (reset_i) begin
            wr_ptr_r     <= '0;
            rd_ptr_r     <= '0;
            count_r      <= '0;
            owed_r       <= CNT_W'(REQ_DEPTH);
            rsp_cred_r   <= RCW'(RSP_CREDITS);
            req_credit_o <= 1'b0;
        end else begin
            if (req_valid_i) begin
                wr_ptr_r <= next_ptr(wr_ptr_r);
            end
            if (pop_w) begin
                rd_ptr_r <= next_ptr(rd_ptr_r);
            end
            count_r      <= count_r + CNT_W'(req_valid_i) - CNT_W'(pop_w);
            owed_r       <= owed_r + CNT_W'(pop_w) - CNT_W'(credit_pulse_w);
            rsp_cred_r   <= rsp_cred_r + RCW'(rsp_credit_i) - RCW'(read_pop_w);
            req_credit_o <= credit_pulse_w;
        end
    end

    always_comb begin
        issue_w.valid      = 1'b0;
        issue_w.op         = head_w.op;
        issue_w.region     = head_region_w;
        issue_w.addr       = head_w.addr;
        issue_w.write_data = head_w.write_data;
        issue_w.write_mask = head_w.write_mask;

        ram_req_o       = issue_w;
        ram_req_o.valid = pop_w && (head_region_w == REGION_RAM);

        io_req_o       = issue_w;
        io_req_o.valid = pop_w && ((head_region_w == REGION_DISPLAY) ||
                                   (head_region_w == REGION_SWITCH));

        // Unmapped reads are tagged too so they return zero in order
        read_tag_o.valid  = read_pop_w;
        read_tag_o.region = head_region_w;
    end

endmodule

/* hdl/system_ram.sv */
`timescale 1ns/100ps

module system_ram
    import chipset_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  wire logic        clk_cpu_i,
    input  wire target_req_t req_i,
    output word_t            read_data_o
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    word_t            mem_r [RAM_WORDS];
    logic [IDX_W-1:0] index_w;
    logic             write_w;

    // Word index, byte offset dropped
    assign index_w = req_i.addr[IDX_W+1:2];

    assign write_w = req_i.valid && (req_i.op == BUS_WRITE) && (req_i.region == REGION_RAM);

    always_ff @(posedge clk_cpu_i) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (write_w && req_i.write_mask[lane]) begin
                mem_r[index_w][lane*8 +: 8] <= req_i.write_data[lane*8 +: 8];
            end
        end
    end

    // Read port sampled every cycle
    always_ff @(posedge clk_cpu_i) begin
        read_data_o <= mem_r[index_w];
    end

endmodule

/* hdl/io_devices.sv */
`timescale 1ns/100ps

module io_devices
    import chipset_pkg::*;
#(
    parameter int SCAN_DIVISOR = 50000
) (
    input  wire logic        clk_cpu_i,
    input  wire logic        reset_i,
    input  wire target_req_t req_i,
    input  wire logic [15:0] switch_async_i,
    output word_t            read_data_o,
    output logic [7:0]       dsp_anode_o,
    output logic [7:0]       dsp_cathode_o
);

    localparam int DIV_W = (SCAN_DIVISOR > 1) ? $clog2(SCAN_DIVISOR) : 1;

    word_t             display_r;
    logic [15:0]       switch_meta_r;
    logic [15:0]       switch_sync_r;
    logic [DIV_W-1:0]  div_r;
    logic [2:0]        digit_r;
    logic [3:0]        nibble_w;

    // Active-low segments, bit 0 is segment a
    function automatic logic [6:0] hex_segments(input logic [3:0] value);
        logic [6:0] seg;
        case (value)
            4'h0:    seg = 7'b100_0000;
            4'h1:    seg = 7'b111_1001;
            4'h2:    seg = 7'b010_0100;
            4'h3:    seg = 7'b011_0000;
            4'h4:    seg = 7'b001_1001;
            4'h5:    seg = 7'b001_0010;
            4'h6:    seg = 7'b000_0010;
            4'h7:    seg = 7'b111_1000;
            4'h8:    seg = 7'b000_0000;
            4'h9:    seg = 7'b001_0000;
            4'hA:    seg = 7'b000_1000;
            4'hB:    seg = 7'b000_0011;
            4'hC:    seg = 7'b100_0110;
            4'hD:    seg = 7'b010_0001;
            4'hE:    seg = 7'b000_0110;
            default: seg = 7'b000_1110;
        endcase
        return seg;
    endfunction

    always_ff @(posedge clk_cpu_i) begin
        if (reset_i) begin
            display_r <= '0;
        end else if (req_i.valid && (req_i.op == BUS_WRITE) &&
                     (req_i.region == REGION_DISPLAY)) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req_i.write_mask[lane]) begin
                    display_r[lane*8 +: 8] <= req_i.write_data[lane*8 +: 8];
                end
            end
        end
    end

    // Two-stage switch synchronizer
    always_ff @(posedge clk_cpu_i) begin
        switch_meta_r <= switch_async_i;
        switch_sync_r <= switch_meta_r;
    end

    always_ff @(posedge clk_cpu_i) begin
        case (req_i.region)
            REGION_DISPLAY: read_data_o <= display_r;
            REGION_SWITCH:  read_data_o <= {16'h0000, switch_sync_r};
            default:        read_data_o <= '0;
        endcase
    end

    // Digit scan
    always_ff @(posedge clk_cpu_i) begin
        if (reset_i) begin
            div_r   <= '0;
            digit_r <= '0;
        end else if (div_r == DIV_W'(SCAN_DIVISOR - 1)) begin
            div_r   <= '0;
            digit_r <= digit_r + 3'd1;
        end else begin
            div_r <= div_r + 1'b1;
        end
    end

    assign nibble_w      = display_r[digit_r*4 +: 4];
    assign dsp_anode_o   = ~(8'b0000_0001 << digit_r);
    // Decimal point kept dark
    assign dsp_cathode_o = {1'b1, hex_segments(nibble_w)};

endmodule

/* hdl/read_merge.sv */
`timescale 1ns/100ps

module read_merge
    import chipset_pkg::*;
(
    input  wire logic      clk_cpu_i,
    input  wire logic      reset_i,
    input  wire read_tag_t read_tag_i,
    input  wire word_t     ram_data_i,
    input  wire word_t     io_data_i,
    output logic           rsp_valid_o,
    output bus_rsp_t       rsp_o
);

    read_tag_t tag_r;

    // Tag lines up with the targets' registered data
    always_ff @(posedge clk_cpu_i) begin
        if (reset_i) begin
            tag_r <= '0;
        end else begin
            tag_r <= read_tag_i;
        end
    end

    assign rsp_valid_o = tag_r.valid;

    always_comb begin
        rsp_o = '0;
        if (tag_r.valid) begin
            case (tag_r.region)
                REGION_RAM:     rsp_o = ram_data_i;
                REGION_DISPLAY: rsp_o = io_data_i;
                REGION_SWITCH:  rsp_o = io_data_i;
                default:        rsp_o = '0;
            endcase
        end
    end

endmodule

/* hdl/chipset.sv */
`timescale 1ns/100ps

module chipset
    import chipset_pkg::*;
#(
    parameter int REQ_DEPTH    = 4,
    parameter int RSP_CREDITS  = 2,
    parameter int RAM_WORDS    = 256,
    parameter int SCAN_DIVISOR = 50000,
    parameter int RESET_CYCLES = 12
) (
    input  wire logic        clk_cpu_i,
    input  wire logic        reset_async_i,

    // Request channel
    input  wire logic        req_valid_i,
    input  wire bus_req_t    req_i,
    output wire logic        req_credit_o,

    // Response channel
    input  wire logic        rsp_credit_i,
    output wire logic        rsp_valid_o,
    output wire bus_rsp_t    rsp_o,

    // Board I/O
    input  wire logic [15:0] switch_async_i,
    output wire logic [7:0]  dsp_anode_o,
    output wire logic [7:0]  dsp_cathode_o
);

    logic        reset_w;
    target_req_t ram_req_w;
    target_req_t io_req_w;
    read_tag_t   read_tag_w;
    word_t       ram_data_w;
    word_t       io_data_w;

    reset_stretch #(
        .RESET_CYCLES (RESET_CYCLES)
    ) reset_inst (
        .clk_cpu_i     (clk_cpu_i),
        .reset_async_i (reset_async_i),
        .reset_o       (reset_w)
    );

    bus_decoder #(
        .REQ_DEPTH   (REQ_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) decoder_inst (
        .clk_cpu_i    (clk_cpu_i),
        .reset_i      (reset_w),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_credit_o (req_credit_o),
        .rsp_credit_i (rsp_credit_i),
        .ram_req_o    (ram_req_w),
        .io_req_o     (io_req_w),
        .read_tag_o   (read_tag_w)
    );

    system_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) ram_inst (
        .clk_cpu_i   (clk_cpu_i),
        .req_i       (ram_req_w),
        .read_data_o (ram_data_w)
    );

    io_devices #(
        .SCAN_DIVISOR (SCAN_DIVISOR)
    ) io_inst (
        .clk_cpu_i      (clk_cpu_i),
        .reset_i        (reset_w),
        .req_i          (io_req_w),
        .switch_async_i (switch_async_i),
        .read_data_o    (io_data_w),
        .dsp_anode_o    (dsp_anode_o),
        .dsp_cathode_o  (dsp_cathode_o)
    );

    read_merge merge_inst (
        .clk_cpu_i   (clk_cpu_i),
        .reset_i     (reset_w),
        .read_tag_i  (read_tag_w),
        .ram_data_i  (ram_data_w),
        .io_data_i   (io_data_w),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

/* testbench/tb_chipset.sv */
`timescale 1ns/100ps

module tb_chipset
    import chipset_pkg::*;
();

    localparam int REQ_DEPTH    = 4;
    localparam int RSP_CREDITS  = 2;
    localparam int RAM_WORDS    = 256;
    localparam int SCAN_DIVISOR = 4;
    localparam int RAM_TESTS    = 8;
    localparam int WAIT_LIMIT   = 100;
    localparam word_t DSP_ADDR  = 32'hFF00_0000;
    localparam word_t SW_ADDR   = 32'hFF00_0004;
    // Budget per test in clock cycles, doubled for margin
    localparam int RUN_CYCLES      = 16 + 60 + 250 + 120 + 40 + 120 + 200;
    localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES;

    logic        clk_cpu;
    logic        reset_async;
    logic        req_valid;
    bus_req_t    req;
    logic        req_credit;
    logic        rsp_credit;
    logic        rsp_valid;
    bus_rsp_t    rsp;
    logic [15:0] switch_async;
    logic [7:0]  dsp_anode;
    logic [7:0]  dsp_cathode;

    int    checks        = 0;
    int    errors        = 0;
    int    req_credits   = 0;
    int    credit_pulses = 0;
    int    rsp_owed      = 0;
    logic  hold_rsp_credits = 1'b0;
    word_t rng_state     = 32'he013_d164;
    word_t rsp_q [$];
    word_t ram_model [RAM_WORDS];
    word_t ram_addrs [RAM_TESTS];

    chipset #(
        .REQ_DEPTH    (REQ_DEPTH),
        .RSP_CREDITS  (RSP_CREDITS),
        .RAM_WORDS    (RAM_WORDS),
        .SCAN_DIVISOR (SCAN_DIVISOR)
    ) chipset_inst (
        .clk_cpu_i      (clk_cpu),
        .reset_async_i  (reset_async),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .req_credit_o   (req_credit),
        .rsp_credit_i   (rsp_credit),
        .rsp_valid_o    (rsp_valid),
        .rsp_o          (rsp),
        .switch_async_i (switch_async),
        .dsp_anode_o    (dsp_anode),
        .dsp_cathode_o  (dsp_cathode)
    );

    initial begin
        clk_cpu = 1'b0;
        forever #20 clk_cpu = ~clk_cpu;
    end

    // Master side bookkeeping, sampled mid-cycle
    always @(negedge clk_cpu) begin
        if (req_credit === 1'b1) begin
            req_credits++;
            credit_pulses++;
        end
        if (rsp_valid === 1'b1) begin
            rsp_q.push_back(rsp);
            rsp_owed++;
        end
    end

    // One response credit back per cycle unless held
    always @(posedge clk_cpu) begin
        #2;
        if (!hold_rsp_credits && rsp_owed > 0) begin
            rsp_credit = 1'b1;
            rsp_owed--;
        end else begin
            rsp_credit = 1'b0;
        end
    end

    function automatic word_t xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic int word_index(input word_t addr);
        return (addr >> 2) % RAM_WORDS;
    endfunction

    function automatic word_t model_read(input word_t addr);
        return ram_model[word_index(addr)];
    endfunction

    // Common-anode hex digits, bit 0 is segment a, bit 7 the dark point
    function automatic logic [7:0] seven_seg_pattern(input logic [3:0] value);
        logic [7:0] pattern;
        case (value)
            4'h0: pattern = 8'hC0;
            4'h1: pattern = 8'hF9;
            4'h2: pattern = 8'hA4;
            4'h3: pattern = 8'hB0;
            4'h4: pattern = 8'h99;
            4'h5: pattern = 8'h92;
            4'h6: pattern = 8'h82;
            4'h7: pattern = 8'hF8;
            4'h8: pattern = 8'h80;
            4'h9: pattern = 8'h90;
            4'hA: pattern = 8'h88;
            4'hB: pattern = 8'h83;
            4'hC: pattern = 8'hC6;
            4'hD: pattern = 8'hA1;
            4'hE: pattern = 8'h86;
            default: pattern = 8'h8E;
        endcase
        return pattern;
    endfunction

    task automatic model_write(input word_t addr, input word_t data, input logic [3:0] mask);
        int idx;
        idx = word_index(addr);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                ram_model[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_cpu);
        #2;
    endtask

    task automatic send_req(input bus_op_e op, input word_t addr,
                            input word_t data, input logic [3:0] mask);
        int waited;
        waited = 0;
        while (req_credits == 0 && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (req_credits == 0) begin
            errors++;
            $display("No request credit arrived by %0t, request to %h not sent", $time, addr);
        end else begin
            req_credits--;
            req_valid      = 1'b1;
            req.op         = op;
            req.addr       = addr;
            req.write_data = data;
            req.write_mask = mask;
            next_cycle();
            req_valid = 1'b0;
        end
    endtask

    task automatic wait_responses(input int count);
        int waited;
        waited = 0;
        while (rsp_q.size() < count && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (rsp_q.size() < count) begin
            errors++;
            $display("Timed out at %0t waiting for %0d responses, only %0d arrived",
                     $time, count, rsp_q.size());
        end
    endtask

    task automatic check_next_response(input word_t expected, input string what);
        word_t got;
        checks++;
        if (rsp_q.size() == 0) begin
            errors++;
            $display("No response left to compare for %s", what);
        end else begin
            got = rsp_q.pop_front();
            if (got !== expected) begin
                errors++;
                $display("FAILED at %0t: %s got %h, expected %h", $time, what, got, expected);
            end
        end
    endtask

    task automatic check_reset_credits();
        int waited;
        waited = 0;
        while (credit_pulses < REQ_DEPTH && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        // Idle window, no further credits may show up
        repeat (20) next_cycle();
        checks++;
        if (credit_pulses != REQ_DEPTH) begin
            errors++;
            $display("FAILED at %0t: %0d credit pulses after reset, expected %0d",
                     $time, credit_pulses, REQ_DEPTH);
        end
    endtask

    task automatic check_ram();
        word_t rnd;
        word_t data;
        for (int i = 0; i < RAM_TESTS; i++) begin
            rnd          = xorshift32();
            ram_addrs[i] = {4'h1, rnd[27:2], 2'b00};
            data         = xorshift32();
            model_write(ram_addrs[i], data, 4'hF);
            send_req(BUS_WRITE, ram_addrs[i], data, 4'hF);
        end
        // Partial byte masks on top
        for (int i = 0; i < RAM_TESTS; i++) begin
            rnd  = xorshift32();
            data = xorshift32();
            model_write(ram_addrs[i], data, rnd[3:0]);
            send_req(BUS_WRITE, ram_addrs[i], data, rnd[3:0]);
        end
        for (int i = 0; i < RAM_TESTS; i++) begin
            send_req(BUS_READ, ram_addrs[i], '0, '0);
        end
        wait_responses(RAM_TESTS);
        for (int i = 0; i < RAM_TESTS; i++) begin
            check_next_response(model_read(ram_addrs[i]), "RAM read");
        end
    endtask

    task automatic check_display_and_unmapped();
        word_t disp;
        disp = 32'hA5C3_0F96;
        send_req(BUS_WRITE, DSP_ADDR, disp, 4'hF);
        send_req(BUS_WRITE, DSP_ADDR, 32'h1234_5678, 4'b0101);
        disp = {disp[31:24], 8'h34, disp[15:8], 8'h78};
        model_write(32'h1000_0010, 32'h0BAD_F00D, 4'hF);
        send_req(BUS_WRITE, 32'h1000_0010, 32'h0BAD_F00D, 4'hF);
        // Both of these land nowhere
        send_req(BUS_WRITE, 32'h3000_0010, 32'hDEAD_BEEF, 4'hF);
        send_req(BUS_WRITE, 32'hFF00_0008, 32'hDEAD_BEEF, 4'hF);
        send_req(BUS_READ, DSP_ADDR, '0, '0);
        send_req(BUS_READ, 32'h3000_0010, '0, '0);
        send_req(BUS_READ, 32'hFF00_0008, '0, '0);
        send_req(BUS_READ, 32'h1000_0010, '0, '0);
        wait_responses(4);
        check_next_response(disp, "display readback");
        check_next_response('0, "unmapped read 0x30000010");
        check_next_response('0, "unmapped read 0xFF000008");
        check_next_response(model_read(32'h1000_0010), "RAM after unmapped write");
    endtask

    task automatic check_switches();
        word_t rnd;
        for (int i = 0; i < 2; i++) begin
            rnd          = xorshift32();
            switch_async = rnd[15:0];
            repeat (3) next_cycle();
            send_req(BUS_READ, SW_ADDR, '0, '0);
            wait_responses(1);
            check_next_response({16'h0000, rnd[15:0]}, "switch read");
        end
    endtask

    task automatic check_display_scan();
        word_t      disp;
        logic [7:0] prev_anode;
        logic [7:0] seen;
        int         digit;
        disp = 32'h9E0F_6BD1;
        send_req(BUS_WRITE, DSP_ADDR, disp, 4'hF);
        send_req(BUS_READ, DSP_ADDR, '0, '0);
        wait_responses(1);
        check_next_response(disp, "display before scan");
        prev_anode = 8'hFF;
        seen       = '0;
        repeat (3 * 8 * SCAN_DIVISOR) begin
            @(negedge clk_cpu);
            if (dsp_anode !== prev_anode) begin
                prev_anode = dsp_anode;
                checks++;
                if ($countones(~dsp_anode) != 1) begin
                    errors++;
                    $display("FAILED at %0t: anode pattern %b does not select one digit",
                             $time, dsp_anode);
                end else begin
                    digit = 0;
                    for (int k = 0; k < 8; k++) begin
                        if (!dsp_anode[k]) begin
                            digit = k;
                        end
                    end
                    seen[digit] = 1'b1;
                    if (dsp_cathode !== seven_seg_pattern(disp[digit*4 +: 4])) begin
                        errors++;
                        $display("FAILED at %0t: digit %0d cathodes %h, expected %h", $time,
                                 digit, dsp_cathode, seven_seg_pattern(disp[digit*4 +: 4]));
                    end
                end
            end
        end
        next_cycle();
        checks++;
        if (seen != 8'hFF) begin
            errors++;
            $display("Not every digit was scanned, digits seen %b", seen);
        end
    endtask

    task automatic check_back_pressure();
        int sent;
        hold_rsp_credits = 1'b1;
        sent             = 0;
        repeat (40) begin
            if (sent < RAM_TESTS && req_credits > 0) begin
                send_req(BUS_READ, ram_addrs[sent], '0, '0);
                sent++;
            end else begin
                next_cycle();
            end
        end
        checks += 3;
        if (sent != REQ_DEPTH + RSP_CREDITS) begin
            errors++;
            $display("FAILED at %0t: %0d reads accepted while stalled, expected %0d",
                     $time, sent, REQ_DEPTH + RSP_CREDITS);
        end
        if (rsp_q.size() != RSP_CREDITS) begin
            errors++;
            $display("FAILED at %0t: %0d responses while stalled, expected %0d",
                     $time, rsp_q.size(), RSP_CREDITS);
        end
        if (req_credits != 0) begin
            errors++;
            $display("FAILED at %0t: %0d request credits left while stalled, expected 0",
                     $time, req_credits);
        end
        hold_rsp_credits = 1'b0;
        while (sent < RAM_TESTS) begin
            send_req(BUS_READ, ram_addrs[sent], '0, '0);
            sent++;
        end
        wait_responses(RAM_TESTS);
        for (int i = 0; i < RAM_TESTS; i++) begin
            check_next_response(model_read(ram_addrs[i]), "read after back-pressure");
        end
    endtask

    initial begin
        reset_async  = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        rsp_credit   = 1'b0;
        switch_async = '0;
        repeat (16) @(posedge clk_cpu);
        #2;
        reset_async = 1'b0;
        check_reset_credits();
        check_ram();
        check_display_and_unmapped();
        check_switches();
        check_display_scan();
        check_back_pressure();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_cpu);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* chipset.f */
hdl/chipset_pkg.sv
hdl/reset_stretch.sv
hdl/bus_decoder.sv
hdl/system_ram.sv
hdl/io_devices.sv
hdl/read_merge.sv
hdl/chipset.sv
testbench/tb_chipset.sv

/* Bender.yml */
package:
  name: chipset

sources:
  - hdl/chipset_pkg.sv
  - hdl/reset_stretch.sv
  - hdl/bus_decoder.sv
  - hdl/system_ram.sv
  - hdl/io_devices.sv
  - hdl/read_merge.sv
  - hdl/chipset.sv
  - target: test
    files:
      - testbench/tb_chipset.sv
